//--- arm_defs.svh
`ifndef ARM_DEFS_SVH
`define ARM_DEFS_SVH

`define DATA_WIDTH     32
`define REG_ADDR_WIDTH 4
`define MEM_ADDR_WIDTH 8
`define PC_REG         15
`define WORD_BYTES     4

// Instruction fields
`define RD_LSB 12
`define RN_LSB 16
`define U_BIT  23
`define L_BIT  20

// Read port A sources
`define SEL_A_RN 2'd0
`define SEL_A_PC 2'd1
`define SEL_A_RD 2'd2
`define SEL_A_RM 2'd3

// B operand sources
`define OPB_REG    2'd0
`define OPB_IMM    2'd1
`define OPB_LD_OFF 2'd2
`define OPB_BR_OFF 2'd3

`endif

//--- armPkg.sv
package armPkg;

  // Data-processing codes in architectural order, then internal ops
  typedef enum logic [4:0] {
    opAnd         = 5'd0,
    opEor         = 5'd1,
    opSub         = 5'd2,
    opRsb         = 5'd3,
    opAdd         = 5'd4,
    opAdc         = 5'd5,
    opSbc         = 5'd6,
    opRsc         = 5'd7,
    opTst         = 5'd8,
    opTeq         = 5'd9,
    opCmp         = 5'd10,
    opCmn         = 5'd11,
    opOrr         = 5'd12,
    opMov         = 5'd13,
    opBic         = 5'd14,
    opMvn         = 5'd15,
    passA         = 5'd16,
    addFour       = 5'd17,
    addWordOffset = 5'd18
  } aluOpT;

  typedef enum logic [2:0] {
    fetch,
    loadIr,
    execDp,
    execBranch,
    calcAddr,
    memRead,
    loadWb,
    memWrite
  } ctrlStateT;

  typedef enum logic [2:0] {
    dpReg,
    dpImm,
    loadStore,
    branch,
    unsupported
  } instClassT;

endpackage

//--- regFile.sv
`timescale 1ns/1ps
`include "arm_defs.svh"

module regFile (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       wrEn,
  input  logic [`REG_ADDR_WIDTH-1:0] wrIdx,
  input  logic [`REG_ADDR_WIDTH-1:0] rdIdxA,
  input  logic [`REG_ADDR_WIDTH-1:0] rdIdxB,
  input  logic [`DATA_WIDTH-1:0]     wrData,
  input  logic                       pcIncEn,
  output logic [`DATA_WIDTH-1:0]     rdDataA,
  output logic [`DATA_WIDTH-1:0]     rdDataB
);

  logic [`DATA_WIDTH-1:0] regs [0:(1 << `REG_ADDR_WIDTH)-1];

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < (1 << `REG_ADDR_WIDTH); i++)
      begin
        regs[i] <= '0;
      end
    end
    else
    begin
      if (pcIncEn)
      begin
        regs[`PC_REG] <= regs[`PC_REG] + `DATA_WIDTH'(`WORD_BYTES);
      end
      // Later assignment wins, so an explicit PC write beats the increment
      if (wrEn)
      begin
        regs[wrIdx] <= wrData;
      end
    end
  end

  assign rdDataA = regs[rdIdxA];
  assign rdDataB = regs[rdIdxB];

endmodule

//--- alu.sv
`timescale 1ns/1ps
`include "arm_defs.svh"

module alu (
  input  logic [`DATA_WIDTH-1:0] opA,
  input  logic [`DATA_WIDTH-1:0] opB,
  input  armPkg::aluOpT          op,
  output logic [`DATA_WIDTH-1:0] result
);

  // No flags, so carry-in is always zero
  always_comb
  begin
    case (op)
      armPkg::opAnd: result = opA & opB;
      armPkg::opEor: result = opA ^ opB;
      armPkg::opSub: result = opA - opB;
      armPkg::opRsb: result = opB - opA;
      armPkg::opAdd: result = opA + opB;
      armPkg::opAdc: result = opA + opB;
      armPkg::opSbc: result = opA - opB - `DATA_WIDTH'(1);
      armPkg::opRsc: result = opB - opA - `DATA_WIDTH'(1);
      armPkg::opOrr: result = opA | opB;
      armPkg::opMov: result = opB;
      armPkg::opBic: result = opA & ~opB;
      armPkg::opMvn: result = ~opB;
      // Compare and test ops never reach the register file
      armPkg::opTst,
      armPkg::opTeq,
      armPkg::opCmp,
      armPkg::opCmn:
      begin
        result = opA;
      end
      armPkg::passA:
      begin
        result = opA;
      end
      armPkg::addFour:
      begin
        result = opA + `DATA_WIDTH'(`WORD_BYTES);
      end
      armPkg::addWordOffset:
      begin
        result = opA + opB * `DATA_WIDTH'(`WORD_BYTES);
      end
      default:
      begin
        result = opA;
      end
    endcase
  end

endmodule

//--- shifterOperand.sv
`timescale 1ns/1ps
`include "arm_defs.svh"

module shifterOperand (
  input  logic [`DATA_WIDTH-1:0] instr,
  input  logic [1:0]             opBSel,
  input  logic [`DATA_WIDTH-1:0] regOperand,
  output logic [`DATA_WIDTH-1:0] operand
);

  logic [`DATA_WIDTH-1:0]   immExt;
  logic [4:0]               rotAmt;
  logic [2*`DATA_WIDTH-1:0] immDouble;
  logic [`DATA_WIDTH-1:0]   immRot;
  logic [`DATA_WIDTH-1:0]   loadOffset;
  logic [`DATA_WIDTH-1:0]   branchOffset;

  assign immExt = {{(`DATA_WIDTH-8){1'b0}}, instr[7:0]};
  assign rotAmt = {instr[11:8], 1'b0};

  // Rotate right by shifting a doubled copy
  assign immDouble = {immExt, immExt} >> rotAmt;
  assign immRot    = immDouble[`DATA_WIDTH-1:0];

  assign loadOffset   = {{(`DATA_WIDTH-12){1'b0}}, instr[11:0]};
  assign branchOffset = {{(`DATA_WIDTH-24){instr[23]}}, instr[23:0]};

  always_comb
  begin
    case (opBSel)
      `OPB_REG:    operand = regOperand;
      `OPB_IMM:    operand = immRot;
      `OPB_LD_OFF: operand = loadOffset;
      default:     operand = branchOffset;
    endcase
  end

endmodule

//--- controlUnit.sv
`timescale 1ns/1ps
`include "arm_defs.svh"

module controlUnit (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`DATA_WIDTH-1:0] instr,
  output logic                   regWrEn,
  output logic                   pcIncEn,
  output logic                   irEn,
  output logic                   addrEn,
  output logic                   memRead,
  output logic                   memWrite,
  output logic                   wrFromMem,
  output logic [1:0]             rdSelA,
  output logic [1:0]             opBSel,
  output armPkg::aluOpT          aluOp
);

  armPkg::ctrlStateT state;
  armPkg::ctrlStateT nextState;
  armPkg::instClassT instClass;

  always_comb
  begin
    case (instr[27:25])
      3'b000:  instClass = armPkg::dpReg;
      3'b001:  instClass = armPkg::dpImm;
      3'b010:  instClass = armPkg::loadStore;
      3'b101:  instClass = armPkg::branch;
      default: instClass = armPkg::unsupported;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      state <= armPkg::fetch;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    nextState = armPkg::fetch;
    regWrEn   = 1'b0;
    pcIncEn   = 1'b0;
    irEn      = 1'b0;
    addrEn    = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    wrFromMem = 1'b0;
    rdSelA    = `SEL_A_RN;
    opBSel    = `OPB_REG;
    aluOp     = armPkg::passA;
    case (state)
      armPkg::fetch:
      begin
        // No strobe while reset is held
        memRead   = rstN;
        pcIncEn   = 1'b1;
        rdSelA    = `SEL_A_PC;
        nextState = armPkg::loadIr;
      end
      armPkg::loadIr:
      begin
        irEn = 1'b1;
        case (instClass)
          armPkg::loadStore: nextState = armPkg::calcAddr;
          armPkg::branch:    nextState = armPkg::execBranch;
          // Unsupported words pass through execDp with no write
          default:           nextState = armPkg::execDp;
        endcase
      end
      armPkg::execDp:
      begin
        aluOp  = armPkg::aluOpT'({1'b0, instr[24:21]});
        opBSel = (instClass == armPkg::dpImm) ? `OPB_IMM : `OPB_REG;
        // TST, TEQ, CMP, CMN are 8 to 11
        regWrEn = (instClass != armPkg::unsupported) && (instr[24:23] != 2'b10);
      end
      armPkg::execBranch:
      begin
        rdSelA  = `SEL_A_PC;
        opBSel  = `OPB_BR_OFF;
        aluOp   = armPkg::addWordOffset;
        regWrEn = 1'b1;
      end
      armPkg::calcAddr:
      begin
        opBSel    = `OPB_LD_OFF;
        aluOp     = instr[`U_BIT] ? armPkg::opAdd : armPkg::opSub;
        addrEn    = 1'b1;
        nextState = instr[`L_BIT] ? armPkg::memRead : armPkg::memWrite;
      end
      armPkg::memRead:
      begin
        memRead   = 1'b1;
        nextState = armPkg::loadWb;
      end
      armPkg::loadWb:
      begin
        regWrEn   = 1'b1;
        wrFromMem = 1'b1;
      end
      armPkg::memWrite:
      begin
        memWrite = 1'b1;
      end
      default:
      begin
        nextState = armPkg::fetch;
      end
    endcase
  end

endmodule

//--- armCore.sv
`timescale 1ns/1ps
`include "arm_defs.svh"

module armCore (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic [`DATA_WIDTH-1:0]     memRdata,
  output logic [`MEM_ADDR_WIDTH-1:0] memAddr,
  output logic [`DATA_WIDTH-1:0]     memWdata,
  output logic                       memRead,
  output logic                       memWrite
);

  logic [`DATA_WIDTH-1:0]     ir;
  logic [`DATA_WIDTH-1:0]     decodeInstr;
  logic [`MEM_ADDR_WIDTH-1:0] addrReg;
  logic                       regWrEn;
  logic                       pcIncEn;
  logic                       irEn;
  logic                       addrEn;
  logic                       wrFromMem;
  logic [1:0]                 rdSelA;
  logic [1:0]                 opBSel;
  armPkg::aluOpT              aluOp;
  logic [`REG_ADDR_WIDTH-1:0] rdField;
  logic [`REG_ADDR_WIDTH-1:0] rnField;
  logic [`REG_ADDR_WIDTH-1:0] rmField;
  logic [`REG_ADDR_WIDTH-1:0] rdIdxA;
  logic [`REG_ADDR_WIDTH-1:0] rdIdxB;
  logic [`REG_ADDR_WIDTH-1:0] wrIdx;
  logic [`DATA_WIDTH-1:0]     rdDataA;
  logic [`DATA_WIDTH-1:0]     rdDataB;
  logic [`DATA_WIDTH-1:0]     opB;
  logic [`DATA_WIDTH-1:0]     aluResult;
  logic [`DATA_WIDTH-1:0]     wrData;

  always_ff @(posedge clk)
  begin
    if (irEn)
    begin
      ir <= memRdata;
    end
    if (addrEn)
    begin
      addrReg <= aluResult[`MEM_ADDR_WIDTH-1:0];
    end
  end

  // The control unit sees the fetched word while the IR is loading
  assign decodeInstr = irEn ? memRdata : ir;

  assign rdField = ir[`RD_LSB +: `REG_ADDR_WIDTH];
  assign rnField = ir[`RN_LSB +: `REG_ADDR_WIDTH];
  assign rmField = ir[`REG_ADDR_WIDTH-1:0];

  always_comb
  begin
    case (rdSelA)
      `SEL_A_RN: rdIdxA = rnField;
      `SEL_A_PC: rdIdxA = `REG_ADDR_WIDTH'(`PC_REG);
      `SEL_A_RD: rdIdxA = rdField;
      default:   rdIdxA = rmField;
    endcase
  end

  // Port B carries the store data during a write
  assign rdIdxB = memWrite ? rdField : rmField;

  // Branches read and write the PC
  assign wrIdx  = (rdSelA == `SEL_A_PC) ? `REG_ADDR_WIDTH'(`PC_REG) : rdField;
  assign wrData = wrFromMem ? memRdata : aluResult;

  assign memAddr  = pcIncEn ? rdDataA[`MEM_ADDR_WIDTH-1:0] : addrReg;
  assign memWdata = rdDataB;

  regFile u_regFile (
    .clk     (clk),
    .rstN    (rstN),
    .wrEn    (regWrEn),
    .wrIdx   (wrIdx),
    .rdIdxA  (rdIdxA),
    .rdIdxB  (rdIdxB),
    .wrData  (wrData),
    .pcIncEn (pcIncEn),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  shifterOperand u_shifterOperand (
    .instr      (ir),
    .opBSel     (opBSel),
    .regOperand (rdDataB),
    .operand    (opB)
  );

  alu u_alu (
    .opA    (rdDataA),
    .opB    (opB),
    .op     (aluOp),
    .result (aluResult)
  );

  controlUnit u_controlUnit (
    .clk       (clk),
    .rstN      (rstN),
    .instr     (decodeInstr),
    .regWrEn   (regWrEn),
    .pcIncEn   (pcIncEn),
    .irEn      (irEn),
    .addrEn    (addrEn),
    .memRead   (memRead),
    .memWrite  (memWrite),
    .wrFromMem (wrFromMem),
    .rdSelA    (rdSelA),
    .opBSel    (opBSel),
    .aluOp     (aluOp)
  );

endmodule

//--- tb_armCore.sv
`timescale 1ns/1ps
`include "arm_defs.svh"

module tb_armCore;

  localparam int memWords      = 64;
  localparam int resetCycles   = 8;
  localparam int cyclesPerWord = 8;
  localparam int timeoutMargin = 100;
  // Several passes of the closing branch loop
  localparam int drainCycles   = 12;

  // ASCII codes of the trace record letters
  localparam int recPreload = 80;
  localparam int recWrite   = 87;
  localparam int recComment = 35;
  localparam int newline    = 10;

  logic                       clk;
  logic                       rstN;
  logic [`DATA_WIDTH-1:0]     memRdata;
  logic [`MEM_ADDR_WIDTH-1:0] memAddr;
  logic [`DATA_WIDTH-1:0]     memWdata;
  logic                       memRead;
  logic                       memWrite;

  logic [`DATA_WIDTH-1:0] mem [0:memWords-1];
  logic [`DATA_WIDTH-1:0] expAddr [$];
  logic [`DATA_WIDTH-1:0] expData [$];
  int                     programWords;
  int                     cycleLimit;
  int                     cycleCount;
  int                     writeIdx;
  logic                   fetchChecked;

  armCore u_dut (
    .clk      (clk),
    .rstN     (rstN),
    .memRdata (memRdata),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .memRead  (memRead),
    .memWrite (memWrite)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #10 clk = ~clk;
    end
  end

  task automatic stopWithError(input string reason);
    begin
      $display("%s", reason);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic checkValue(input string name, input logic [`DATA_WIDTH-1:0] actual,
                            input logic [`DATA_WIDTH-1:0] expected);
    begin
      if (actual !== expected)
      begin
        stopWithError($sformatf("FAILED %s: got 0x%08h, expected 0x%08h",
                                name, actual, expected));
      end
    end
  endtask

  // Skips whitespace and returns the next character, or -1 at end of file
  function automatic int nextChar(input int fd);
    int c;
    begin
      c = $fgetc(fd);
      while (c >= 0 && c <= 32)
      begin
        c = $fgetc(fd);
      end
      return c;
    end
  endfunction

  task automatic loadTrace();
    int                     fd;
    int                     kind;
    int                     count;
    logic [`DATA_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] data;
    begin
      fd = $fopen("armCore_trace.txt", "r");
      if (fd == 0)
      begin
        stopWithError("Cannot open the trace file armCore_trace.txt");
      end
      kind = nextChar(fd);
      while (kind != -1)
      begin
        if (kind == recComment)
        begin
          while (kind != newline && kind != -1)
          begin
            kind = $fgetc(fd);
          end
        end
        else
        begin
          count = $fscanf(fd, "%h %h", addr, data);
          if (count != 2 || addr >= (1 << `MEM_ADDR_WIDTH) ||
              (kind != recPreload && kind != recWrite))
          begin
            stopWithError("The trace file holds a record that cannot be read");
          end
          if (kind == recPreload)
          begin
            mem[addr[`MEM_ADDR_WIDTH-1:2]] = data;
            programWords++;
          end
          else
          begin
            expAddr.push_back(addr);
            expData.push_back(data);
          end
        end
        kind = nextChar(fd);
      end
      $fclose(fd);
    end
  endtask

  task automatic tickCycle();
    begin
      cycleCount++;
      if (cycleCount > cycleLimit)
      begin
        stopWithError($sformatf("Timeout after %0d cycles with %0d of %0d stores seen",
                                cycleCount, writeIdx, expAddr.size()));
      end
    end
  endtask

  // Memory model, called on each falling edge
  task automatic serviceMemory();
    begin
      if (memRead && memWrite)
      begin
        stopWithError("Read and write strobes are high in the same cycle");
      end
      if (memRead)
      begin
        if (!fetchChecked)
        begin
          checkValue("memAddr", `DATA_WIDTH'(memAddr), '0);
          fetchChecked = 1'b1;
        end
        memRdata = mem[memAddr[`MEM_ADDR_WIDTH-1:2]];
      end
      if (memWrite)
      begin
        if (writeIdx >= expAddr.size())
        begin
          stopWithError("The core made a store that the trace does not expect");
        end
        checkValue("memAddr", `DATA_WIDTH'(memAddr), expAddr[writeIdx]);
        checkValue("memWdata", memWdata, expData[writeIdx]);
        mem[memAddr[`MEM_ADDR_WIDTH-1:2]] = memWdata;
        writeIdx++;
      end
    end
  endtask

  initial
  begin
    rstN         = 1'b0;
    memRdata     = '0;
    programWords = 0;
    cycleCount   = 0;
    writeIdx     = 0;
    fetchChecked = 1'b0;
    // Unsupported encodings tagged with their byte address
    for (int i = 0; i < memWords; i++)
    begin
      mem[i] = 32'hE600_0000 | `DATA_WIDTH'(i * `WORD_BYTES);
    end
    loadTrace();
    cycleLimit = cyclesPerWord * programWords + timeoutMargin;

    for (int i = 0; i < resetCycles; i++)
    begin
      @(negedge clk);
      checkValue("memRead", `DATA_WIDTH'(memRead), '0);
      checkValue("memWrite", `DATA_WIDTH'(memWrite), '0);
      tickCycle();
    end
    // The next rising edge is the first one out of reset
    rstN = 1'b1;
    // Fetch strobe follows the release within this half cycle
    @(posedge memRead or posedge clk);
    checkValue("memRead", `DATA_WIDTH'(memRead), `DATA_WIDTH'(1));
    serviceMemory();

    while (writeIdx < expAddr.size())
    begin
      @(negedge clk);
      serviceMemory();
      tickCycle();
    end
    repeat (drainCycles)
    begin
      @(negedge clk);
      serviceMemory();
      tickCycle();
    end
    $display("Test passed");
    $finish;
  end

endmodule

//--- armCore_trace.txt
# P addr data preloads a memory word, W addr data is the next expected store
# Addresses are byte addresses in hex, data words are hex
P 00 E3A014FF
P 04 E58010C0
P 08 E3A0213F
P 0C E58020C4
P 10 E3A03EAB
P 14 E3A0403C
# Register ops on R3 = 0xAB0 and R4 = 0x3C into R5
P 18 E0035004
P 1C E58050C8
P 20 E0235004
P 24 E58050CC
P 28 E0435004
P 2C E58050D0
P 30 E0635004
P 34 E58050D4
P 38 E0835004
P 3C E58050D8
P 40 E0A35004
P 44 E58050DC
P 48 E0C35004
P 4C E58050E0
P 50 E0E35004
P 54 E58050E4
P 58 E1835004
P 5C E58050E8
P 60 E1A05004
P 64 E58050EC
P 68 E1C35004
P 6C E58050F0
P 70 E1E05004
P 74 E58050F4
P 78 E1135004
P 7C E58050F8
P 80 E1535004
P 84 E58050FC
# Loads with up and down offsets
P 88 E59060B8
P 8C E58060C0
P 90 E3A070F0
P 94 E5178034
P 98 E507802C
# Branch over a store, then store R15, then spin
P 9C EA000001
P A0 E58010C8
P A4 E580F0CC
P A8 EAFFFFFF
P B8 13579BDF
P BC 2468ACE0
W C0 FF000000
W C4 C000000F
W C8 00000030
W CC 00000A8C
W D0 00000A74
W D4 FFFFF58C
W D8 00000AEC
W DC 00000AEC
W E0 00000A73
W E4 FFFFF58B
W E8 00000ABC
W EC 0000003C
W F0 00000A80
W F4 FFFFFFC3
W F8 FFFFFFC3
W FC FFFFFFC3
W C0 13579BDF
W C4 2468ACE0
W CC 000000A8

//--- vlog.f
+incdir+.
armPkg.sv
regFile.sv
alu.sv
shifterOperand.sv
controlUnit.sv
armCore.sv
tb_armCore.sv

//--- Makefile
SOURCES = arm_defs.svh armPkg.sv regFile.sv alu.sv shifterOperand.sv \
          controlUnit.sv armCore.sv tb_armCore.sv vlog.f

.PHONY: all run clean

all: obj_dir/VtbarmCore

obj_dir/VtbarmCore: $(SOURCES)
	verilator --binary -f vlog.f --top-module tb_armCore -o VtbarmCore

run: obj_dir/VtbarmCore
	./obj_dir/VtbarmCore

clean:
	rm -rf obj_dir
